/* rtl/mem_arb_pkg.sv */
`default_nettype none

package mem_arb_pkg;

    // byte address seen by both caches and by memory
    localparam int addr_w = 32;

    // one cache line and one memory beat
    localparam int line_w = 256;
    localparam int beat_w = 64;

    // beats in one line, lowest beat first on the bus
    localparam int beats_per_line = line_w / beat_w;

    // line addresses are aligned, so these low bits are zero
    localparam int line_offset_w = 5;

    // counts beats 0 to beats_per_line-1
    localparam int beat_cnt_w = 2;

    // arbiter state
    // arb_pass lets client requests through,
    // arb_wait_write replays a posted write that is still pending
    typedef enum logic {
        arb_pass       = 1'b0,
        arb_wait_write = 1'b1
    } arb_state_t;

    // burst adapter state
    typedef enum logic [1:0] {
        adp_idle        = 2'b00,
        adp_read_burst  = 2'b01,
        adp_write_burst = 2'b10,
        adp_respond     = 2'b11
    } adp_state_t;

endpackage

`default_nettype wire

/* rtl/line_arbiter.sv */
`default_nettype none

module line_arbiter (
    input  logic                           clk,
    input  logic                           rst,

    // instruction cache, read only
    input  logic                           icache_read,
    input  logic [mem_arb_pkg::addr_w-1:0] icache_addr,
    output logic                           icache_ready,

    // data cache, reads and posted writes
    input  logic                           dcache_read,
    input  logic                           dcache_write,
    input  logic [mem_arb_pkg::addr_w-1:0] dcache_addr,
    input  logic [mem_arb_pkg::line_w-1:0] dcache_wdata,
    output logic                           dcache_ready,

    // request towards the burst adapter
    output logic                           line_read,
    output logic                           line_write,
    output logic [mem_arb_pkg::addr_w-1:0] line_addr,
    output logic [mem_arb_pkg::line_w-1:0] line_wdata,
    input  logic                           line_ready
);

    import mem_arb_pkg::*;

    arb_state_t state;
    arb_state_t state_next;

    // posted write buffer
    logic [addr_w-1:0] wbuf_addr;
    logic [line_w-1:0] wbuf_data;

    // the write pulse is only one cycle long, so keep a copy in case
    // the adapter is busy
    always_ff @(posedge clk) begin
        if (dcache_write) begin
            wbuf_addr <= dcache_addr;
            wbuf_data <= dcache_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_pass;
        end else begin
            state <= state_next;
        end
    end

    // request select and ready routing
    always_comb begin
        icache_ready = 1'b0;
        dcache_ready = 1'b0;
        line_read    = 1'b0;
        line_write   = 1'b0;
        line_addr    = '0;
        line_wdata   = '0;

        unique case (state)
            arb_pass: begin
                if (dcache_read || dcache_write) begin
                    // data cache first
                    line_read    = dcache_read;
                    line_write   = dcache_write;
                    line_addr    = dcache_addr;
                    line_wdata   = dcache_wdata;
                    dcache_ready = line_ready;
                end else if (icache_read) begin
                    line_read    = 1'b1;
                    line_addr    = icache_addr;
                    icache_ready = line_ready;
                end
            end

            arb_wait_write: begin
                // reads from both sides are held off until the write is taken
                line_write   = 1'b1;
                line_addr    = wbuf_addr;
                line_wdata   = wbuf_data;
                dcache_ready = line_ready;
            end

            default: begin
            end
        endcase
    end

    always_comb begin
        state_next = state;

        unique case (state)
            arb_pass: begin
                // write not taken on its own cycle, replay it from the buffer
                if (dcache_write && !line_ready) begin
                    state_next = arb_wait_write;
                end
            end

            arb_wait_write: begin
                if (line_ready) begin
                    state_next = arb_pass;
                end
            end

            default: begin
                state_next = arb_pass;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/line_burst_adapter.sv */
`default_nettype none

module line_burst_adapter (
    input  logic                           clk,
    input  logic                           rst,

    // line request from the arbiter
    input  logic                           line_read,
    input  logic                           line_write,
    input  logic [mem_arb_pkg::addr_w-1:0] line_addr,
    input  logic [mem_arb_pkg::line_w-1:0] line_wdata,
    output logic                           line_ready,

    // read response, broadcast to both caches
    output logic                           rvalid,
    output logic [mem_arb_pkg::line_w-1:0] rdata,
    output logic [mem_arb_pkg::addr_w-1:0] raddr,

    // burst memory port
    output logic                           mem_read,
    output logic                           mem_write,
    output logic [mem_arb_pkg::addr_w-1:0] mem_addr,
    output logic [mem_arb_pkg::beat_w-1:0] mem_wdata,
    input  logic [mem_arb_pkg::beat_w-1:0] mem_rdata,
    input  logic                           mem_resp
);

    import mem_arb_pkg::*;

    adp_state_t state;
    adp_state_t state_next;

    logic [beat_cnt_w-1:0] beat_cnt;
    logic                  last_resp;
    logic                  accept;

    // line address of the burst in flight
    logic [addr_w-1:0] addr_q;

    // one register holds the write line while it drains and the
    // read line while it fills
    logic [line_w-1:0] line_q;

    assign accept    = (state == adp_idle) && (line_read || line_write);
    assign last_resp = mem_resp && (beat_cnt == beat_cnt_w'(beats_per_line - 1));

    assign line_ready = accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= adp_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;

        unique case (state)
            adp_idle: begin
                if (line_write) begin
                    state_next = adp_write_burst;
                end else if (line_read) begin
                    state_next = adp_read_burst;
                end
            end

            adp_read_burst: begin
                if (last_resp) begin
                    state_next = adp_respond;
                end
            end

            adp_write_burst: begin
                if (last_resp) begin
                    state_next = adp_idle;
                end
            end

            adp_respond: begin
                // rvalid lasts exactly this one cycle
                state_next = adp_idle;
            end

            default: begin
                state_next = adp_idle;
            end
        endcase
    end

    // beat counter wraps back to zero after the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (accept) begin
            beat_cnt <= '0;
        end else if (mem_resp && (mem_read || mem_write)) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // burst address and line data
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= {line_addr[addr_w-1:line_offset_w], {line_offset_w{1'b0}}};
            line_q <= line_wdata;
        end else if (mem_resp && (mem_read || mem_write)) begin
            // lowest beat goes first; a read shifts in from the top so the
            // first beat ends up in the lowest bits after the last one
            line_q <= {mem_rdata, line_q[line_w-1:beat_w]};
        end
    end

    assign mem_read  = (state == adp_read_burst);
    assign mem_write = (state == adp_write_burst);
    assign mem_addr  = addr_q;
    assign mem_wdata = line_q[beat_w-1:0];

    assign rvalid = (state == adp_respond);
    assign rdata  = line_q;
    assign raddr  = addr_q;

endmodule

`default_nettype wire

/* rtl/mem_subsys_top.sv */
`default_nettype none

module mem_subsys_top (
    input  logic                           clk,
    input  logic                           rst,

    // instruction cache
    input  logic                           icache_read,
    input  logic [mem_arb_pkg::addr_w-1:0] icache_addr,
    output logic                           icache_ready,
    output logic                           icache_rvalid,
    output logic [mem_arb_pkg::line_w-1:0] icache_rdata,
    output logic [mem_arb_pkg::addr_w-1:0] icache_raddr,

    // data cache
    input  logic                           dcache_read,
    input  logic                           dcache_write,
    input  logic [mem_arb_pkg::addr_w-1:0] dcache_addr,
    input  logic [mem_arb_pkg::line_w-1:0] dcache_wdata,
    output logic                           dcache_ready,
    output logic                           dcache_rvalid,
    output logic [mem_arb_pkg::line_w-1:0] dcache_rdata,
    output logic [mem_arb_pkg::addr_w-1:0] dcache_raddr,

    // burst memory port
    output logic                           mem_read,
    output logic                           mem_write,
    output logic [mem_arb_pkg::addr_w-1:0] mem_addr,
    output logic [mem_arb_pkg::beat_w-1:0] mem_wdata,
    input  logic [mem_arb_pkg::beat_w-1:0] mem_rdata,
    input  logic                           mem_resp
);

    import mem_arb_pkg::*;

    // arbiter to adapter
    logic              line_read;
    logic              line_write;
    logic [addr_w-1:0] line_addr;
    logic [line_w-1:0] line_wdata;
    logic              line_ready;

    // read response from the adapter
    logic              rvalid;
    logic [line_w-1:0] rdata;
    logic [addr_w-1:0] raddr;

    line_arbiter line_arbiter_inst (
        .clk          (clk),
        .rst          (rst),
        .icache_read  (icache_read),
        .icache_addr  (icache_addr),
        .icache_ready (icache_ready),
        .dcache_read  (dcache_read),
        .dcache_write (dcache_write),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_ready (dcache_ready),
        .line_read    (line_read),
        .line_write   (line_write),
        .line_addr    (line_addr),
        .line_wdata   (line_wdata),
        .line_ready   (line_ready)
    );

    line_burst_adapter line_burst_adapter_inst (
        .clk        (clk),
        .rst        (rst),
        .line_read  (line_read),
        .line_write (line_write),
        .line_addr  (line_addr),
        .line_wdata (line_wdata),
        .line_ready (line_ready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .raddr      (raddr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_resp   (mem_resp)
    );

    // both caches see every returned line and filter by raddr themselves
    assign icache_rvalid = rvalid;
    assign icache_rdata  = rdata;
    assign icache_raddr  = raddr;
    assign dcache_rvalid = rvalid;
    assign dcache_rdata  = rdata;
    assign dcache_raddr  = raddr;

endmodule

`default_nettype wire

/* tb/mem_subsys_asserts.sv */
`default_nettype none

module mem_subsys_asserts (
    input wire logic                           clk,
    input wire logic                           rst,
    input wire logic                           icache_ready,
    input wire logic                           dcache_ready,
    input wire logic                           mem_read,
    input wire logic                           mem_write,
    input wire logic [mem_arb_pkg::addr_w-1:0] mem_addr,
    input wire logic                           rvalid
);

    // number of property failures so far
    int fail_count = 0;

    // only one client is accepted per cycle
    assert property (@(posedge clk) disable iff (rst) !(icache_ready && dcache_ready))
        else begin
            fail_count++;
            $error("icache_ready and dcache_ready high together");
        end

    assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else begin
            fail_count++;
            $error("mem_read and mem_write high together");
        end

    // line address is held for the whole burst
    assert property (@(posedge clk) disable iff (rst)
        (mem_read || mem_write) ##1 (mem_read || mem_write) |-> $stable(mem_addr))
        else begin
            fail_count++;
            $error("mem_addr changed during a burst");
        end

    assert property (@(posedge clk) disable iff (rst) rvalid |=> !rvalid)
        else begin
            fail_count++;
            $error("rvalid longer than one cycle");
        end

endmodule

bind mem_subsys_top mem_subsys_asserts mem_subsys_asserts_inst (
    .clk          (clk),
    .rst          (rst),
    .icache_ready (icache_ready),
    .dcache_ready (dcache_ready),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .rvalid       (icache_rvalid)
);

`default_nettype wire

/* tb/mem_subsys_tb.sv */
`default_nettype none

module mem_subsys_tb;

    import mem_arb_pkg::*;

    localparam int n_ops = 200;
    // 0 to 3 wait cycles plus the response cycle
    localparam int max_wait = 4;
    // an operation can hold up to three line requests
    localparam int timeout_cycles = n_ops * 3 * (beats_per_line * max_wait + 8);

    logic clk = 1'b0;
    logic rst;
    logic icache_read, dcache_read, dcache_write, mem_resp;
    logic [addr_w-1:0] icache_addr, dcache_addr, icache_raddr, dcache_raddr, mem_addr;
    logic [line_w-1:0] dcache_wdata, icache_rdata, dcache_rdata;
    logic [beat_w-1:0] mem_wdata, mem_rdata;
    logic icache_ready, dcache_ready, icache_rvalid, dcache_rvalid, mem_read, mem_write;

    // stimulus bookkeeping
    logic ic_active = 1'b0, dc_rd_active = 1'b0, wr_issue = 1'b0, wr_pending = 1'b0;
    logic [addr_w-1:0] ic_addr, dc_rd_addr, wr_addr;
    logic [line_w-1:0] wr_data;
    logic [addr_w-1:0] rd_q[$], wq_addr[$];
    logic [line_w-1:0] wq_data[$];
    logic [line_w-1:0] ref_line[logic [addr_w-1:0]];
    logic [beat_w-1:0] mem_beat[logic [addr_w-1:0]];
    logic [31:0] rng_stim = 32'h5def05dd;
    logic [31:0] rng_mem = 32'h5def05dd ^ 32'h9e3779b9;
    int cycles = 0;

    mem_subsys_top mem_subsys_top_inst (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(inout logic [31:0] s);
        s = s * 32'd1664525 + 32'd1013904223;
        return s;
    endfunction

    // unwritten memory derives every beat from its own byte address
    function automatic logic [beat_w-1:0] fill_beat(logic [addr_w-1:0] a);
        return {a ^ 32'h3c96a5f0, ~a};
    endfunction

    function automatic logic [line_w-1:0] expected_line(logic [addr_w-1:0] a);
        logic [line_w-1:0] l;
        if (ref_line.exists(a)) begin
            return ref_line[a];
        end
        for (int b = 0; b < beats_per_line; b++) begin
            l[b*beat_w +: beat_w] = fill_beat(a + addr_w'(b * 8));
        end
        return l;
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_line(string name, logic [line_w-1:0] got, logic [line_w-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, logic [addr_w-1:0] got, logic [addr_w-1:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // memory responder gives one beat per mem_resp after a random gap
    int beat = 0;
    int wait_left = 0;
    logic [line_w-1:0] wline;
    always @(negedge clk) begin
        mem_resp = 1'b0;
        if (!rst && (mem_read || mem_write)) begin
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                mem_resp = 1'b1;
                if (mem_read) begin
                    mem_rdata = mem_beat.exists(mem_addr + addr_w'(beat * 8)) ?
                        mem_beat[mem_addr + addr_w'(beat * 8)] :
                        fill_beat(mem_addr + addr_w'(beat * 8));
                end else begin
                    mem_beat[mem_addr + addr_w'(beat * 8)] = mem_wdata;
                    wline[beat*beat_w +: beat_w] = mem_wdata;
                end
                beat++;
                if (beat == beats_per_line) begin
                    beat = 0;
                    if (mem_write) begin
                        if (wq_data.size() == 0) begin
                            fail_now("write burst on the memory port without an accepted write");
                        end
                        check_addr("mem_addr", mem_addr, wq_addr.pop_front());
                        check_line("mem_wdata beats", wline, wq_data.pop_front());
                    end
                end
                wait_left = lcg_next(rng_mem) % 4;
            end
        end
    end

    // sample after the falling edge inputs have settled
    task automatic monitor();
        logic [addr_w-1:0] a;
        cycles++;
        if (cycles > timeout_cycles) begin
            fail_now("timeout: the run hung waiting for a ready or rvalid");
        end
        if (mem_subsys_top_inst.mem_subsys_asserts_inst.fail_count != 0) begin
            fail_now("a protocol assertion on the DUT ports failed");
        end
        if (dcache_ready) begin
            if (wr_pending) begin
                ref_line[wr_addr] = wr_data;
                wq_addr.push_back(wr_addr);
                wq_data.push_back(wr_data);
                wr_pending = 1'b0;
            end else if (dc_rd_active) begin
                rd_q.push_back(dc_rd_addr);
                dc_rd_active = 1'b0;
            end else begin
                fail_now("dcache_ready pulsed with no data cache request");
            end
        end
        if (icache_ready) begin
            if (!ic_active || dc_rd_active || wr_pending) begin
                fail_now("icache_ready pulsed without a request or ahead of the data cache");
            end
            rd_q.push_back(ic_addr);
            ic_active = 1'b0;
        end
        if (icache_rvalid || dcache_rvalid) begin
            if (rd_q.size() == 0) begin
                fail_now("rvalid with no accepted read outstanding");
            end
            a = rd_q.pop_front();
            check_bit("icache_rvalid", icache_rvalid, 1'b1);
            check_bit("dcache_rvalid", dcache_rvalid, 1'b1);
            check_addr("icache_raddr", icache_raddr, a);
            check_addr("dcache_raddr", dcache_raddr, a);
            check_line("icache_rdata", icache_rdata, expected_line(a));
            check_line("dcache_rdata", dcache_rdata, expected_line(a));
        end
    endtask

    task automatic tick();
        @(negedge clk);
        icache_read  = ic_active;
        icache_addr  = ic_addr;
        dcache_read  = dc_rd_active;
        dcache_write = wr_issue;
        dcache_addr  = wr_issue ? wr_addr : dc_rd_addr;
        dcache_wdata = wr_data;
        if (wr_issue) begin
            wr_issue   = 1'b0;
            wr_pending = 1'b1;
        end
        #1;
        monitor();
    endtask

    task automatic issue_write(logic [addr_w-1:0] a);
        wr_addr = a;
        for (int w = 0; w < line_w / 32; w++) begin
            wr_data[w*32 +: 32] = lcg_next(rng_stim);
        end
        wr_issue = 1'b1;
    endtask

    function automatic logic [addr_w-1:0] rand_line_addr();
        return 32'h0000_1000 + ((lcg_next(rng_stim) % 16) << line_offset_w);
    endfunction

    initial begin
        int op;
        {icache_read, dcache_read, dcache_write, mem_resp} = '0;
        {icache_addr, dcache_addr, dcache_wdata, mem_rdata} = '0;
        {ic_addr, dc_rd_addr, wr_addr, wr_data} = '0;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) begin
            tick();
            check_bit("icache_ready", icache_ready, 1'b0);
            check_bit("dcache_ready", dcache_ready, 1'b0);
            check_bit("mem_read", mem_read, 1'b0);
            check_bit("mem_write", mem_write, 1'b0);
            check_bit("icache_rvalid", icache_rvalid, 1'b0);
            check_bit("dcache_rvalid", dcache_rvalid, 1'b0);
        end
        for (int i = 0; i < n_ops; i++) begin
            op = lcg_next(rng_stim) % 6;
            case (op)
                0: begin
                    ic_active = 1'b1;
                    ic_addr   = rand_line_addr();
                end
                1: begin
                    dc_rd_active = 1'b1;
                    dc_rd_addr   = rand_line_addr();
                end
                2: issue_write(rand_line_addr());
                3: begin
                    ic_active = 1'b1;
                    ic_addr   = rand_line_addr();
                    issue_write(rand_line_addr());
                end
                4: begin
                    // the write lands while a read burst is in flight,
                    // then a read right behind the posted write
                    ic_active = 1'b1;
                    ic_addr   = rand_line_addr();
                    while (ic_active) begin
                        tick();
                    end
                    issue_write(rand_line_addr());
                    tick();
                    dc_rd_active = 1'b1;
                    dc_rd_addr   = wr_addr;
                end
                default: begin
                    ic_active    = 1'b1;
                    ic_addr      = rand_line_addr();
                    dc_rd_active = 1'b1;
                    dc_rd_addr   = rand_line_addr();
                end
            endcase
            while (ic_active || dc_rd_active || wr_issue || wr_pending ||
                   rd_q.size() != 0 || wq_data.size() != 0) begin
                tick();
            end
            repeat (lcg_next(rng_stim) % 2) tick();
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rtl/mem_arb_pkg.sv
rtl/line_arbiter.sv
rtl/line_burst_adapter.sv
rtl/mem_subsys_top.sv
tb/mem_subsys_asserts.sv
tb/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - rtl/mem_arb_pkg.sv
  - rtl/line_arbiter.sv
  - rtl/line_burst_adapter.sv
  - rtl/mem_subsys_top.sv
  - target: test
    files:
      - tb/mem_subsys_asserts.sv
      - tb/mem_subsys_tb.sv
